// File: hdl/vpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_core
    import vpu_pkg::*, vpu_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,

    // instruction memory
    output pc_t       pc,
    input  instr_t    instr,

    // register write report
    output logic      data_out_vld,
    output vec_t      data_out,
    output reg_addr_t reg_wb
);

    logic      jump;
    pc_t       jump_target;
    vec_t      rd1;
    vec_t      rd2;
    logic      wb_we;
    reg_addr_t wb_addr;
    vec_t      wb_data;

    vpu_issue_if issue ();

    // ==================================================================
    // fetch and decode
    // ==================================================================

    vpu_fetch u_fetch (
        .clk         (clk         ),
        .rst_n       (rst_n       ),
        .en          (en          ),
        .jump        (jump        ),
        .jump_target (jump_target ),
        .pc          (pc          )
    );

    vpu_decoder u_decoder (
        .instr       (instr       ),
        .issue       (issue       ),
        .jump        (jump        ),
        .jump_target (jump_target )
    );

    // read addresses come straight from the decoded fields
    vpu_vrf u_vrf (
        .clk         (clk         ),
        .rst_n       (rst_n       ),
        .wen         (wb_we       ),
        .addr_w      (wb_addr     ),
        .data_w      (wb_data     ),
        .addr_r1     (issue.vs1   ),
        .addr_r2     (issue.vs2   ),
        .data_r1     (rd1         ),
        .data_r2     (rd2         )
    );

    // ==================================================================
    // execute and writeback
    // ==================================================================

    vpu_execute u_execute (
        .clk         (clk         ),
        .rst_n       (rst_n       ),
        .en          (en          ),
        .issue       (issue       ),
        .rd1         (rd1         ),
        .rd2         (rd2         ),
        .wb_we       (wb_we       ),
        .wb_addr     (wb_addr     ),
        .wb_data     (wb_data     )
    );

    // every register write is reported
    assign data_out_vld = wb_we;
    assign data_out     = wb_data;
    assign reg_wb       = wb_addr;

endmodule

`default_nettype wire

// File: hdl/vpu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_decoder
    import vpu_pkg::*, vpu_isa_pkg::*;
(
    input  instr_t               instr,

    vpu_issue_if.producer        issue,

    output logic                 jump,
    output pc_t                  jump_target
);

    logic [OP_W-1:0] op_raw;

    assign op_raw = instr[OP_HI:OP_LO];

    // ==================================================================
    // field extraction
    // ==================================================================

    assign issue.vd  = instr[VD_HI:VD_LO];
    assign issue.vs1 = instr[VS1_HI:VS1_LO];
    assign issue.vs2 = instr[VS2_HI:VS2_LO];
    assign issue.imm = instr[IMM_HI:IMM_LO];

    // jump target is the low imm bits
    assign jump_target = instr[IMM_LO +: PC_W];

    // ==================================================================
    // control
    // ==================================================================

    always_comb begin
        issue.op     = OP_NOP;
        issue.reg_we = 1'b0;
        jump         = 1'b0;
        case (op_raw)
            OP_VADD, OP_VSUB, OP_VAND, OP_VOR, OP_VXOR, OP_VSLLI, OP_VBCAST: begin
                issue.op     = opcode_e'(op_raw);
                issue.reg_we = 1'b1;
            end
            OP_JUMP: begin
                issue.op = OP_JUMP;
                jump     = 1'b1;
            end
            // unknown encodings fall through as a no-op
            default: begin
                issue.op = OP_NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/vpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_execute
    import vpu_pkg::*, vpu_isa_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,

    vpu_issue_if.consumer issue,

    // register file data read in ID
    input  vec_t          rd1,
    input  vec_t          rd2,

    // register file write port, also the core outputs
    output logic          wb_we,
    output reg_addr_t     wb_addr,
    output vec_t          wb_data
);

    // EX1
    opcode_e   op_ex1;
    logic      we_ex1;
    reg_addr_t vd_ex1;
    reg_addr_t vs1_ex1;
    reg_addr_t vs2_ex1;
    imm_t      imm_ex1;
    vec_t      rd1_ex1;
    vec_t      rd2_ex1;
    vec_t      opa;
    vec_t      opb;
    vec_t      res_ex1;

    // EX2 and WB
    logic      we_ex2;
    reg_addr_t vd_ex2;
    vec_t      res_ex2;
    logic      we_wb;
    reg_addr_t vd_wb;
    vec_t      res_wb;

    // ==================================================================
    // EX1 pipeline register
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_ex1 <= OP_NOP;
            we_ex1 <= 1'b0;
        end else if (en) begin
            op_ex1 <= issue.op;
            we_ex1 <= issue.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            vd_ex1  <= issue.vd;
            vs1_ex1 <= issue.vs1;
            vs2_ex1 <= issue.vs2;
            imm_ex1 <= issue.imm;
            rd1_ex1 <= rd1;
            rd2_ex1 <= rd2;
        end
    end

    // ==================================================================
    // operand forwarding
    // ==================================================================

    // newest producer wins: EX2, then WB, then the register file
    always_comb begin
        if (we_ex2 && (vs1_ex1 == vd_ex2)) begin
            opa = res_ex2;
        end else if (we_wb && (vs1_ex1 == vd_wb)) begin
            opa = res_wb;
        end else begin
            opa = rd1_ex1;
        end

        if (we_ex2 && (vs2_ex1 == vd_ex2)) begin
            opb = res_ex2;
        end else if (we_wb && (vs2_ex1 == vd_wb)) begin
            opb = res_wb;
        end else begin
            opb = rd2_ex1;
        end
    end

    // one ALU per lane
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        vpu_lane_alu u_lane_alu (
            .op  (op_ex1                      ),
            .a   (opa[l*LANE_W +: LANE_W]     ),
            .b   (opb[l*LANE_W +: LANE_W]     ),
            .imm (imm_ex1                     ),
            .y   (res_ex1[l*LANE_W +: LANE_W] )
        );
    end

    // ==================================================================
    // EX2 and WB pipeline registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_ex2 <= 1'b0;
            we_wb  <= 1'b0;
        end else if (en) begin
            we_ex2 <= we_ex1;
            we_wb  <= we_ex2;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            vd_ex2  <= vd_ex1;
            res_ex2 <= res_ex1;
            vd_wb   <= vd_ex2;
            res_wb  <= res_ex2;
        end
    end

    // no write while the core is frozen
    assign wb_we   = en && we_wb;
    assign wb_addr = vd_wb;
    assign wb_data = res_wb;

endmodule

`default_nettype wire

// File: hdl/vpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_fetch
    import vpu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic en,

    // jump decoded in ID
    input  logic jump,
    input  pc_t  jump_target,

    output pc_t  pc
);

    pc_t pc_next;

    // no delay slot, the jump target follows the jump directly
    always_comb begin
        if (jump) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc + pc_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (en) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/vpu_isa_pkg.sv
`default_nettype none

package vpu_isa_pkg;

    // ==================================================================
    // instruction format
    // ==================================================================

    localparam int INSTR_W = 32;
    localparam int OP_W    = 5;
    localparam int IMM_W   = 12;

    // field positions
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 27;
    localparam int VD_HI  = 26;
    localparam int VD_LO  = 22;
    localparam int VS1_HI = 21;
    localparam int VS1_LO = 17;
    localparam int VS2_HI = 16;
    localparam int VS2_LO = 12;
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;

    // shift amount taken from the low imm bits
    localparam int SHAMT_W = 4;

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [IMM_W-1:0]   imm_t;

    typedef enum logic [OP_W-1:0] {
        OP_NOP    = 5'd0,
        OP_VADD   = 5'd1,
        OP_VSUB   = 5'd2,
        OP_VAND   = 5'd3,
        OP_VOR    = 5'd4,
        OP_VXOR   = 5'd5,
        OP_VSLLI  = 5'd6,
        OP_VBCAST = 5'd7,
        OP_JUMP   = 5'd8
    } opcode_e;

endpackage

`default_nettype wire

// File: hdl/vpu_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// one decoded instruction in ID, moving from decoder to execute
interface vpu_issue_if
    import vpu_pkg::*, vpu_isa_pkg::*;
();

    opcode_e   op;
    reg_addr_t vd;
    reg_addr_t vs1;
    reg_addr_t vs2;
    imm_t      imm;
    // set for ops that write vd
    logic      reg_we;

    modport producer (
        output op, vd, vs1, vs2, imm, reg_we
    );

    // sampled on enabled edges only
    modport consumer (
        input op, vd, vs1, vs2, imm, reg_we
    );

endinterface

`default_nettype wire

// File: hdl/vpu_lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_lane_alu
    import vpu_pkg::*, vpu_isa_pkg::*;
(
    input  opcode_e op,
    input  lane_t   a,
    input  lane_t   b,
    input  imm_t    imm,
    output lane_t   y
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = imm[SHAMT_W-1:0];

    always_comb begin
        case (op)
            // add and sub wrap at the lane width
            OP_VADD:   y = a + b;
            OP_VSUB:   y = a - b;
            OP_VAND:   y = a & b;
            OP_VOR:    y = a | b;
            OP_VXOR:   y = a ^ b;
            OP_VSLLI:  y = a << shamt;
            // zero-extended imm in every lane
            OP_VBCAST: y = lane_t'(imm);
            // nop and jump write nothing
            default:   y = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/vpu_pkg.sv
`default_nettype none

package vpu_pkg;

    // ==================================================================
    // datapath geometry
    // ==================================================================

    // lanes per vector and bits per lane
    localparam int LANES  = 4;
    localparam int LANE_W = 16;
    localparam int VEC_W  = LANES * LANE_W;

    // vector register file
    localparam int REG_DEPTH  = 32;
    localparam int REG_ADDR_W = $clog2(REG_DEPTH);

    // instruction memory address
    localparam int PC_W = 8;

    // ==================================================================
    // datapath types
    // ==================================================================

    typedef logic [LANE_W-1:0]     lane_t;
    // lane 0 sits in the low bits
    typedef logic [VEC_W-1:0]      vec_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;

endpackage

`default_nettype wire

// File: hdl/vpu_vrf.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_vrf
    import vpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // write port, driven from WB
    input  logic      wen,
    input  reg_addr_t addr_w,
    input  vec_t      data_w,

    // read ports, used in ID
    input  reg_addr_t addr_r1,
    input  reg_addr_t addr_r2,
    output vec_t      data_r1,
    output vec_t      data_r2
);

    vec_t regs [REG_DEPTH];

    // a read of the register being written returns the new value
    function automatic vec_t read_port(
        input reg_addr_t addr,
        input vec_t      stored,
        input logic      w_en,
        input reg_addr_t w_addr,
        input vec_t      w_data
    );
        if (w_en && (addr == w_addr)) begin
            return w_data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[addr_w] <= data_w;
        end
    end

    assign data_r1 = read_port(addr_r1, regs[addr_r1], wen, addr_w, data_w);
    assign data_r2 = read_port(addr_r2, regs[addr_r2], wen, addr_w, data_w);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_vpu_core -f vpu_core.f -o tb_vpu_core

out=$(./obj_dir/tb_vpu_core || true)
echo "$out"

if echo "$out" | grep -q "TEST OK"; then
    exit 0
fi
exit 1

// File: tb/tb_vpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vpu_core
    import vpu_pkg::*, vpu_isa_pkg::*;
();

    localparam int          PROG_DEPTH    = 1 << PC_W;
    localparam int          RAND_COUNT    = 200;
    localparam int          FIRST_LATENCY = 3;
    localparam int          DRAIN_CYCLES  = 10;
    localparam logic [31:0] LFSR_SEED     = 32'habc2_9040;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    logic        clk;
    logic        rst_n;
    logic        en;
    pc_t         pc;
    instr_t      instr;
    logic        data_out_vld;
    vec_t        data_out;
    reg_addr_t   reg_wb;

    instr_t      prog [PROG_DEPTH];
    int          wr_ptr;
    pc_t         halt_pc;
    logic [31:0] lfsr;
    reg_addr_t   exp_reg_q [$];
    vec_t        exp_vec_q [$];
    int          gaps [$];
    int          gap_total = 0;
    int          cycle_limit;
    int          cycle_count = 0;
    int          edges_done = 0;
    pc_t         pc_model = '0;
    logic        first_seen = 1'b0;
    logic        fail_reported = 1'b0;
    logic        run_passed = 1'b0;

    vpu_clk_gen u_clk_gen (
        .clk   (clk   ),
        .rst_n (rst_n )
    );

    vpu_core u_vpu_core (
        .clk          (clk          ),
        .rst_n        (rst_n        ),
        .en           (en           ),
        .pc           (pc           ),
        .instr        (instr        ),
        .data_out_vld (data_out_vld ),
        .data_out     (data_out     ),
        .reg_wb       (reg_wb       )
    );

    // instruction memory answers pc without delay
    assign instr = prog[pc];

    // ==================================================================
    // error reporting and compare tasks
    // ==================================================================

    task automatic abort_run();
        fail_reported = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    task automatic check_vec(input vec_t got, input vec_t exp);
        if (got !== exp) begin
            $display("FAILED data_out: got 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("FAILED reg_wb: got 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("FAILED pc: got 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    // ==================================================================
    // random source and program build
    // ==================================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic void emit(input logic [OP_W-1:0] op, input int vd, input int vs1,
                                 input int vs2, input int imm);
        instr_t w;
        w = '0;
        w[OP_HI:OP_LO]   = op;
        w[VD_HI:VD_LO]   = reg_addr_t'(vd);
        w[VS1_HI:VS1_LO] = reg_addr_t'(vs1);
        w[VS2_HI:VS2_LO] = reg_addr_t'(vs2);
        w[IMM_HI:IMM_LO] = imm_t'(imm);
        prog[pc_t'(wr_ptr)] = w;
        wr_ptr++;
    endfunction

    function automatic void build_program();
        logic [OP_W-1:0] op;
        int sel;
        int r;
        int imm;
        int tgt;
        prog   = '{default: '0};
        wr_ptr = 0;
        // broadcast sources, pc 0 writes first
        emit(OP_VBCAST, 1, 0, 0, 'h123);
        emit(OP_VBCAST, 2, 0, 0, 'hf0f);
        emit(OP_VBCAST, 3, 0, 0, 'h005);
        emit(OP_NOP, 0, 0, 0, 0);
        // independent lane ops
        emit(OP_VADD, 4, 1, 2, 0);
        emit(OP_VSUB, 5, 1, 2, 0);
        emit(OP_VAND, 6, 1, 2, 0);
        emit(OP_VOR, 7, 1, 3, 0);
        emit(OP_VXOR, 8, 2, 3, 0);
        emit(OP_VSLLI, 9, 1, 0, 'h004);
        emit(OP_VSLLI, 10, 2, 0, 'hfff);
        // dependent chains at distance 1, 2 and 3
        emit(OP_VADD, 11, 1, 1, 0);
        emit(OP_VADD, 12, 11, 2, 0);
        emit(OP_VSUB, 13, 12, 11, 0);
        emit(OP_NOP, 0, 0, 0, 0);
        emit(OP_VXOR, 14, 13, 12, 0);
        emit(OP_VOR, 15, 3, 3, 0);
        emit(OP_NOP, 0, 0, 0, 0);
        emit(OP_NOP, 0, 0, 0, 0);
        emit(OP_VAND, 16, 15, 15, 0);
        // same register written twice in a row
        emit(OP_VBCAST, 17, 0, 0, 1);
        emit(OP_VBCAST, 17, 0, 0, 2);
        emit(OP_VADD, 18, 17, 17, 0);
        // jump over three writes, v20 stays zero
        emit(OP_JUMP, 0, 0, 0, wr_ptr + 4);
        emit(OP_VBCAST, 20, 0, 0, 'h7ff);
        emit(OP_VBCAST, 20, 0, 0, 'h0aa);
        emit(OP_VBCAST, 19, 0, 0, 'h055);
        emit(OP_VADD, 21, 20, 1, 0);
        // jump to next address, then onto another jump
        emit(OP_JUMP, 0, 0, 0, wr_ptr + 1);
        emit(OP_JUMP, 0, 0, 0, wr_ptr + 2);
        emit(OP_VBCAST, 22, 0, 0, 'h111);
        emit(OP_JUMP, 0, 0, 0, wr_ptr + 2);
        emit(OP_VBCAST, 23, 0, 0, 'h222);
        emit(OP_VXOR, 24, 21, 18, 0);
        emit(OP_VSUB, 0, 3, 1, 0);
        emit(OP_VADD, 25, 0, 0, 0);

        // random section, forward jumps only
        halt_pc = pc_t'(wr_ptr + RAND_COUNT);
        for (int i = 0; i < RAND_COUNT; i++) begin
            sel = int'(rand_bits(4));
            imm = int'(rand_bits(12));
            if (sel < 14) begin
                op = OP_W'(1 + sel % 7);
            end else if (sel == 14) begin
                op  = OP_JUMP;
                tgt = wr_ptr + 1 + int'(rand_bits(3));
                if (tgt > int'(halt_pc)) begin
                    tgt = int'(halt_pc);
                end
                imm = (imm & 'hf00) | tgt;
            end else begin
                // nop or an unused encoding 9..31
                r  = int'(rand_bits(5));
                op = (r == 0) ? OP_NOP : OP_W'(9 + r % 23);
            end
            emit(op, int'(rand_bits(3)), int'(rand_bits(3)), int'(rand_bits(3)), imm);
        end
        // halt by jumping onto itself
        emit(OP_JUMP, 0, 0, 0, wr_ptr);
    endfunction

    // ==================================================================
    // reference model
    // ==================================================================

    function automatic lane_t lane_ref(input logic [OP_W-1:0] op, input lane_t a,
                                       input lane_t b, input imm_t imm);
        case (op)
            OP_VADD:   return a + b;
            OP_VSUB:   return a - b;
            OP_VAND:   return a & b;
            OP_VOR:    return a | b;
            OP_VXOR:   return a ^ b;
            OP_VSLLI:  return a << imm[3:0];
            OP_VBCAST: return {{(LANE_W-IMM_W){1'b0}}, imm};
            default:   return '0;
        endcase
    endfunction

    // runs the program in order and queues each register write
    function automatic void run_reference();
        vec_t            model_regs [REG_DEPTH];
        vec_t            va;
        vec_t            vb;
        vec_t            res;
        instr_t          w;
        logic [OP_W-1:0] op;
        int              p;
        int              steps;
        model_regs = '{default: '0};
        p          = 0;
        steps      = 0;
        while (p != int'(halt_pc) && steps < PROG_DEPTH) begin
            w     = prog[pc_t'(p)];
            op    = w[OP_HI:OP_LO];
            steps = steps + 1;
            if (op == OP_JUMP) begin
                p = int'(w[PC_W-1:0]);
            end else begin
                if (op inside {OP_VADD, OP_VSUB, OP_VAND, OP_VOR, OP_VXOR, OP_VSLLI,
                               OP_VBCAST}) begin
                    va  = model_regs[w[VS1_HI:VS1_LO]];
                    vb  = model_regs[w[VS2_HI:VS2_LO]];
                    res = '0;
                    // top lane first, shifted up as lower lanes follow
                    for (int l = LANES - 1; l >= 0; l--) begin
                        res = {res[VEC_W-LANE_W-1:0],
                               lane_ref(op, lane_t'(va >> (l * LANE_W)),
                                        lane_t'(vb >> (l * LANE_W)), w[IMM_HI:IMM_LO])};
                    end
                    model_regs[w[VD_HI:VD_LO]] = res;
                    exp_reg_q.push_back(w[VD_HI:VD_LO]);
                    exp_vec_q.push_back(res);
                end
                p = p + 1;
            end
        end
    endfunction

    function automatic void build_gaps();
        int g;
        for (int k = 0; k <= int'(halt_pc); k++) begin
            g = 0;
            if (rand_bits(3) < 2) begin
                g = 1 + int'(rand_bits(2));
            end
            gaps.push_back(g);
            gap_total = gap_total + g;
        end
    endfunction

    // ==================================================================
    // compare and timeout
    // ==================================================================

    // outputs are stable mid-cycle, en was driven at the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_pc(pc, pc_model);
            if (data_out_vld) begin
                if (exp_reg_q.size() == 0) begin
                    report_problem("register write reported with no expected result left");
                end else if (!first_seen && edges_done != FIRST_LATENCY) begin
                    report_problem($sformatf("first write came after %0d enabled edges",
                                             edges_done));
                end else begin
                    first_seen = 1'b1;
                    check_reg(reg_wb, exp_reg_q.pop_front());
                    check_vec(data_out, exp_vec_q.pop_front());
                end
            end
            // next pc from the program, no delay slot
            if (en) begin
                edges_done = edges_done + 1;
                if (prog[pc_model][OP_HI:OP_LO] == OP_JUMP) begin
                    pc_model = prog[pc_model][PC_W-1:0];
                end else begin
                    pc_model = pc_model + pc_t'(1);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            report_problem($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    final begin
        if (!run_passed && !fail_reported) begin
            $display("TEST FAILED");
        end
    end

    // ==================================================================
    // stimulus
    // ==================================================================

    initial begin
        en   = 1'b1;
        lfsr = LFSR_SEED;
        build_program();
        run_reference();
        build_gaps();
        cycle_limit = 2 * (int'(halt_pc) + 1) + gap_total + 100;

        wait (rst_n === 1'b1);
        @(posedge clk);
        foreach (gaps[k]) begin
            repeat (gaps[k]) begin
                @(posedge clk);
                en <= 1'b0;
            end
            @(posedge clk);
            en <= 1'b1;
        end

        // run on until the halt jump sits in ID
        @(negedge clk);
        while (pc != halt_pc) begin
            @(posedge clk);
            en <= 1'b1;
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            en <= 1'b1;
        end
        @(negedge clk);

        if (exp_reg_q.size() != 0) begin
            report_problem($sformatf("%0d expected register writes never appeared",
                                     exp_reg_q.size()));
        end else begin
            run_passed = 1'b1;
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/vpu_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released on a rising edge, seen by the core one edge later
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/vpu_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_core_properties
    import vpu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic en,
    input pc_t  pc,
    input logic data_out_vld
);

    // no write report while reset is held
    a_quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !data_out_vld
    ) else $error("data_out_vld high during reset");

    // a frozen core keeps its program counter
    a_pc_holds_when_frozen: assert property (
        @(posedge clk) (rst_n && !en) |=> $stable(pc)
    ) else $error("pc changed across an edge with en low");

    a_output_needs_en: assert property (
        @(posedge clk) data_out_vld |-> en
    ) else $error("data_out_vld high while en is low");

endmodule

bind vpu_core vpu_core_properties u_vpu_core_properties (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .en           (en           ),
    .pc           (pc           ),
    .data_out_vld (data_out_vld )
);

`default_nettype wire

// File: vpu_core.f
hdl/vpu_pkg.sv
hdl/vpu_isa_pkg.sv
hdl/vpu_issue_if.sv
hdl/vpu_fetch.sv
hdl/vpu_decoder.sv
hdl/vpu_vrf.sv
hdl/vpu_lane_alu.sv
hdl/vpu_execute.sv
hdl/vpu_core.sv
tb/vpu_clk_gen.sv
tb/vpu_core_properties.sv
tb/tb_vpu_core.sv
